// File: src/ddrc_ctrl_settings.svh
// ------------------------------------------------------------
// bus widths, register map and reset values of the DDR3
// control block; addresses are Wishbone word addresses
// entries without a mask are exact matches (DDRC_EXACT_MSK)
// ------------------------------------------------------------
`ifndef DDRC_CTRL_SETTINGS_SVH
`define DDRC_CTRL_SETTINGS_SVH

`define DDRC_ADR_BITS 10 // word address width
`define DDRC_DAT_BITS 32 // data bus width

`define DDRC_EXACT_MSK    10'h3ff // full compare

`define DDRC_DLY_LD_ADR   10'h080 // delay load, adr[6:0] selects the delay
`define DDRC_DLY_LD_MSK   10'h380
`define DDRC_DLY_SET_ADR  10'h070 // apply all loaded delays at once
`define DDRC_DLY_SET_MSK  10'h3ff
`define DDRC_RUN_ADR      10'h000 // sequencer run, adr[3:0] is the channel
`define DDRC_RUN_MSK      10'h3f0
`define DDRC_PATT_ADR     10'h020 // {dqm, dqs} patterns
`define DDRC_TRI_ADR      10'h021 // tristate on/off nibbles
`define DDRC_WBUF_ADR     10'h022 // write buffer enable delay
`define DDRC_PAGES_ADR    10'h023 // buffer pages
`define DDRC_CMDA_ADR     10'h024 // level taken from adr[0]
`define DDRC_CMDA_MSK     10'h3fe
`define DDRC_SDRST_ADR    10'h026
`define DDRC_SDRST_MSK    10'h3fe
`define DDRC_CKE_ADR      10'h028
`define DDRC_CKE_MSK      10'h3fe
`define DDRC_DCI_ADR      10'h02a
`define DDRC_DCI_MSK      10'h3fe
`define DDRC_DLYRST_ADR   10'h02c
`define DDRC_DLYRST_MSK   10'h3fe
`define DDRC_EXTRA_ADR    10'h02e // inv_clk_div in dat[0]

`define DDRC_PATT_RST     16'h0055 // dqm 00, dqs 55
`define DDRC_TRI_RST      16'hc3e7 // dqs last/first, dq last/first
`define DDRC_WBUF_RST     4'd6

`endif

// File: src/ddrc_ctrl_pkg.sv
// ------------------------------------------------------------
// types shared by the control block; every union view is
// one full data word with the unused upper bits as padding
// ------------------------------------------------------------
`include "ddrc_ctrl_settings.svh"

package ddrc_ctrl_pkg;

    typedef struct packed {
        logic [1:0] port1_page;     // port 1 buffer write page
        logic [1:0] port1_int_page; // port 1 PHY side read page
        logic [1:0] port0_page;     // port 0 buffer read page
        logic [1:0] port0_int_page; // port 0 PHY side write page
    } ctrl_pages_t;

    typedef union packed {
        logic [`DDRC_DAT_BITS-1:0] raw;
        struct packed {
            logic [`DDRC_DAT_BITS-17:0] pad;
            logic [7:0]                 dqm; // upper byte
            logic [7:0]                 dqs;
        } patt_w;
        struct packed {
            logic [`DDRC_DAT_BITS-17:0] pad;
            logic [3:0]                 dqs_off;
            logic [3:0]                 dqs_on;
            logic [3:0]                 dq_off;
            logic [3:0]                 dq_on;
        } tri_w;
        struct packed {
            logic [`DDRC_DAT_BITS-9:0] pad;
            ctrl_pages_t               pg;
        } pages_w;
        struct packed {
            logic [`DDRC_DAT_BITS-12:0] pad;
            logic [10:0]                run_addr; // msb set means auto mode
        } run_w;
        struct packed {
            logic [`DDRC_DAT_BITS-9:0] pad;
            logic [7:0]                dly; // fine delay or MMCM phase
        } dly_w;
        struct packed {
            logic [`DDRC_DAT_BITS-5:0] pad;
            logic [3:0]                wbuf_delay;
        } nib_w;
        struct packed {
            logic [`DDRC_DAT_BITS-2:0] pad;
            logic                      inv_clk_div;
        } bit_w;
    } ctrl_data_u;

    typedef struct packed {
        logic                      valid; // one cycle per accepted write
        logic [`DDRC_ADR_BITS-1:0] adr;
        ctrl_data_u                dat;
    } ctrl_cmd_t;

    typedef struct packed {
        logic dly_ld;
        logic dly_set;
        logic run;
        logic patt;
        logic tri_pat;
        logic wbuf;
        logic pages;
        logic cmda;
        logic sdrst;
        logic cke;
        logic dci;
        logic dlyrst;
        logic extra;
    } ctrl_sel_t;

    typedef struct packed {
        logic cmda_en;     // drive cmd/addr lines
        logic ddr_rst;     // DDR3 reset, high after system reset
        logic dci_rst;
        logic dly_rst;
        logic ddr_cke;
        logic inv_clk_div; // invert clk_div to ISERDES
    } ctrl_levels_t;

    typedef struct packed {
        logic [7:0] dqs_pattern;
        logic [7:0] dqm_pattern;
        logic [3:0] dqs_tri_off;
        logic [3:0] dqs_tri_on;
        logic [3:0] dq_tri_off;
        logic [3:0] dq_tri_on;
        logic [3:0] wbuf_delay; // extra cycles on write buffer enable
    } ctrl_patt_t;

    typedef struct packed {
        logic [7:0] dly_data;
        logic [6:0] dly_addr;
        logic       ld_delay; // one cycle pulse
        logic       dly_set;  // one cycle pulse
    } dly_cmd_t;

    typedef struct packed {
        logic [10:0] run_addr;
        logic [3:0]  run_chn;
        logic        run_seq; // one cycle pulse
    } seq_cmd_t;

endpackage

// File: src/ddrc_wb_slave.sv
// ------------------------------------------------------------
// Wishbone classic slave, writes only; a read ends with err
// ack/err come one cycle after the request, master must drop
// stb after it; no wait states are ever inserted
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "ddrc_ctrl_settings.svh"

module ddrc_wb_slave (
    input  logic                      clk,
    input  logic                      mclk,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [`DDRC_ADR_BITS-1:0] adr,
    input  logic [`DDRC_DAT_BITS-1:0] dat,
    output logic                      ack,
    output logic                      err,
    output ddrc_ctrl_pkg::ctrl_cmd_t  cmd
);

    logic                      req;      // cycle requested this clock
    logic                      fresh;    // not yet answered
    logic                      wr_take;
    logic                      rd_take;
    logic                      valid_r;
    logic [`DDRC_ADR_BITS-1:0] adr_r;
    logic [`DDRC_DAT_BITS-1:0] dat_r;

    assign req     = cyc & stb;
    assign fresh   = ~(ack | err);    // strobe still high in the answer cycle
    assign wr_take = req & we & fresh;
    assign rd_take = req & ~we & fresh;

    always_ff @(posedge clk or posedge mclk) begin
        if (mclk) begin
            ack     <= 1'b0;
            err     <= 1'b0;
            valid_r <= 1'b0;
        end else begin
            ack     <= wr_take;
            err     <= rd_take;   // reads are not supported
            valid_r <= wr_take;   // command rides along with ack
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            adr_r <= adr;
            dat_r <= dat;
        end
    end

    assign cmd = {valid_r, adr_r, dat_r};

    // every request gets exactly one single cycle answer
    a_one_answer: assert property (@(posedge clk) disable iff (mclk)
        (ack || err) |-> !(ack && err) ##1 !(ack || err));

endmodule

// File: src/ddrc_cmd_decode.sv
// ------------------------------------------------------------
// register map decoder, purely combinational
// at most one strobe is set, and only while cmd.valid is high
// unmapped addresses give no strobe at all
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "ddrc_ctrl_settings.svh"

module ddrc_cmd_decode (
    input  ddrc_ctrl_pkg::ctrl_cmd_t cmd,
    output ddrc_ctrl_pkg::ctrl_sel_t sel
);

    // address hits when all bits under the mask agree
    function automatic logic hit(
        input logic [`DDRC_ADR_BITS-1:0] a,
        input logic [`DDRC_ADR_BITS-1:0] base,
        input logic [`DDRC_ADR_BITS-1:0] msk
    );
        return ((a ^ base) & msk) == '0;
    endfunction

    always_comb begin
        sel = '0;
        if (cmd.valid) begin
            // pulse commands
            sel.dly_ld  = hit(cmd.adr, `DDRC_DLY_LD_ADR, `DDRC_DLY_LD_MSK);
            sel.dly_set = hit(cmd.adr, `DDRC_DLY_SET_ADR, `DDRC_DLY_SET_MSK);
            sel.run     = hit(cmd.adr, `DDRC_RUN_ADR, `DDRC_RUN_MSK); // 16 channels
            // data registers, exact match
            sel.patt    = hit(cmd.adr, `DDRC_PATT_ADR, `DDRC_EXACT_MSK);
            sel.tri_pat = hit(cmd.adr, `DDRC_TRI_ADR, `DDRC_EXACT_MSK);
            sel.wbuf    = hit(cmd.adr, `DDRC_WBUF_ADR, `DDRC_EXACT_MSK);
            sel.pages   = hit(cmd.adr, `DDRC_PAGES_ADR, `DDRC_EXACT_MSK);
            sel.extra   = hit(cmd.adr, `DDRC_EXTRA_ADR, `DDRC_EXACT_MSK);
            // level controls, adr[0] is the new level
            sel.cmda    = hit(cmd.adr, `DDRC_CMDA_ADR, `DDRC_CMDA_MSK);
            sel.sdrst   = hit(cmd.adr, `DDRC_SDRST_ADR, `DDRC_SDRST_MSK);
            sel.cke     = hit(cmd.adr, `DDRC_CKE_ADR, `DDRC_CKE_MSK);
            sel.dci     = hit(cmd.adr, `DDRC_DCI_ADR, `DDRC_DCI_MSK);
            sel.dlyrst  = hit(cmd.adr, `DDRC_DLYRST_ADR, `DDRC_DLYRST_MSK);
        end
        // map regions must stay disjoint
        a_sel_onehot: assert ($onehot0(sel))
            else $error("ddrc_cmd_decode: adr %h hits %b", cmd.adr, sel);
    end

endmodule

// File: src/ddrc_ctrl_regs.sv
// ------------------------------------------------------------
// held control registers, loaded one cycle after the strobe
// levels follow adr[0] of the write, the data of such a
// write is ignored; DDR3 reset is active after system reset
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "ddrc_ctrl_settings.svh"

module ddrc_ctrl_regs (
    input  logic                        clk,
    input  logic                        mclk,
    input  ddrc_ctrl_pkg::ctrl_cmd_t    cmd,
    input  ddrc_ctrl_pkg::ctrl_sel_t    sel,
    output ddrc_ctrl_pkg::ctrl_levels_t levels,
    output ddrc_ctrl_pkg::ctrl_patt_t   patt,
    output ddrc_ctrl_pkg::ctrl_pages_t  pages
);

    always_ff @(posedge clk or posedge mclk) begin
        if (mclk) begin
            levels.cmda_en     <= 1'b0;   // cmd/addr lines tristated
            levels.ddr_rst     <= 1'b1;   // memory held in reset
            levels.dci_rst     <= 1'b0;
            levels.dly_rst     <= 1'b0;
            levels.ddr_cke     <= 1'b0;
            levels.inv_clk_div <= 1'b0;
            {patt.dqm_pattern, patt.dqs_pattern} <= `DDRC_PATT_RST;
            {patt.dqs_tri_off, patt.dqs_tri_on,
             patt.dq_tri_off, patt.dq_tri_on}   <= `DDRC_TRI_RST;
            patt.wbuf_delay    <= `DDRC_WBUF_RST;
            pages              <= '0;
        end else begin
            // level controls
            if (sel.cmda)   levels.cmda_en <= cmd.adr[0];
            if (sel.sdrst)  levels.ddr_rst <= cmd.adr[0];
            if (sel.cke)    levels.ddr_cke <= cmd.adr[0];
            if (sel.dci)    levels.dci_rst <= cmd.adr[0];
            if (sel.dlyrst) levels.dly_rst <= cmd.adr[0];
            if (sel.extra)  levels.inv_clk_div <= cmd.dat.bit_w.inv_clk_div;
            // data registers
            if (sel.patt) begin
                patt.dqm_pattern <= cmd.dat.patt_w.dqm;
                patt.dqs_pattern <= cmd.dat.patt_w.dqs;
            end
            if (sel.tri_pat) begin
                patt.dqs_tri_off <= cmd.dat.tri_w.dqs_off;
                patt.dqs_tri_on  <= cmd.dat.tri_w.dqs_on;
                patt.dq_tri_off  <= cmd.dat.tri_w.dq_off;
                patt.dq_tri_on   <= cmd.dat.tri_w.dq_on;
            end
            if (sel.wbuf)  patt.wbuf_delay <= cmd.dat.nib_w.wbuf_delay;
            if (sel.pages) pages <= cmd.dat.pages_w.pg; // same bit order as the word
        end
    end

endmodule

// File: src/ddrc_cmd_pulses.sv
// ------------------------------------------------------------
// one cycle command pulses with their operands
// operands stay valid until the next command of their kind
// run_seq is dropped while the DDR3 reset level is active
// ------------------------------------------------------------
`timescale 1ns/1ps

module ddrc_cmd_pulses (
    input  logic                     clk,
    input  logic                     mclk,
    input  ddrc_ctrl_pkg::ctrl_cmd_t cmd,
    input  ddrc_ctrl_pkg::ctrl_sel_t sel,
    input  logic                     ddr_rst,
    output ddrc_ctrl_pkg::dly_cmd_t  dly,
    output ddrc_ctrl_pkg::seq_cmd_t  seq
);

    always_ff @(posedge clk or posedge mclk) begin
        if (mclk) begin
            dly <= '0;
            seq <= '0;
        end else begin
            dly.ld_delay <= sel.dly_ld;
            dly.dly_set  <= sel.dly_set;
            seq.run_seq  <= sel.run & ~ddr_rst; // no sequencer while memory in reset
            if (sel.dly_ld) begin
                dly.dly_data <= cmd.dat.dly_w.dly;
                dly.dly_addr <= cmd.adr[6:0];   // delay register select
            end
            if (sel.run) begin
                seq.run_addr <= cmd.dat.run_w.run_addr;
                seq.run_chn  <= cmd.adr[3:0];   // I/O buffer channel
            end
        end
    end

    // ddr_rst comes from the register block, a later write can not
    // raise it under a pending run pulse
    a_run_gated: assert property (@(posedge clk) disable iff (mclk)
        seq.run_seq |-> !ddr_rst);

endmodule

// File: src/ddrc_control_top.sv
// ------------------------------------------------------------
// DDR3 controller configuration block, single clock domain
// two edges from Wishbone request to the effect on outputs
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "ddrc_ctrl_settings.svh"

module ddrc_control_top (
    input  logic                        clk,
    input  logic                        mclk,
    input  logic                        cyc,
    input  logic                        stb,
    input  logic                        we,
    input  logic [`DDRC_ADR_BITS-1:0]   adr,
    input  logic [`DDRC_DAT_BITS-1:0]   dat,
    output logic                        ack,
    output logic                        err,
    output ddrc_ctrl_pkg::ctrl_levels_t levels,
    output ddrc_ctrl_pkg::ctrl_patt_t   patt,
    output ddrc_ctrl_pkg::ctrl_pages_t  pages,
    output ddrc_ctrl_pkg::dly_cmd_t     dly,
    output ddrc_ctrl_pkg::seq_cmd_t     seq
);

    import ddrc_ctrl_pkg::*;

    ctrl_cmd_t cmd; // accepted write, valid with ack
    ctrl_sel_t sel; // decoded strobes, same cycle

    ddrc_wb_slave u_wb_slave (
        .clk  (clk),
        .mclk (mclk),
        .cyc  (cyc),
        .stb  (stb),
        .we   (we),
        .adr  (adr),
        .dat  (dat),
        .ack  (ack),
        .err  (err),
        .cmd  (cmd)
    );

    ddrc_cmd_decode u_cmd_decode (
        .cmd (cmd),
        .sel (sel)
    );

    ddrc_ctrl_regs u_ctrl_regs (
        .clk    (clk),
        .mclk   (mclk),
        .cmd    (cmd),
        .sel    (sel),
        .levels (levels),
        .patt   (patt),
        .pages  (pages)
    );

    ddrc_cmd_pulses u_cmd_pulses (
        .clk     (clk),
        .mclk    (mclk),
        .cmd     (cmd),
        .sel     (sel),
        .ddr_rst (levels.ddr_rst), // gates run_seq
        .dly     (dly),
        .seq     (seq)
    );

endmodule

// File: bench/tb_ddrc_model.svh
// ------------------------------------------------------------
// reference model of the control register map, included in
// the testbench module body after the package import
// holds the expected outputs for the cycle being checked
// ------------------------------------------------------------
`ifndef TB_DDRC_MODEL_SVH
`define TB_DDRC_MODEL_SVH

    ctrl_levels_t m_levels; // expected level controls
    ctrl_patt_t   m_patt;
    ctrl_pages_t  m_pages;
    dly_cmd_t     m_dly;    // operands plus pulse bits
    seq_cmd_t     m_seq;

    task automatic reset_model();
        m_levels         = '0;
        m_levels.ddr_rst = 1'b1;   // memory starts in reset
        m_patt.dqs_pattern = 8'h55;
        m_patt.dqm_pattern = 8'h00;
        m_patt.dqs_tri_off = 4'hc; // dqs last
        m_patt.dqs_tri_on  = 4'h3; // dqs first
        m_patt.dq_tri_off  = 4'he; // dq last
        m_patt.dq_tri_on   = 4'h7; // dq first
        m_patt.wbuf_delay  = 4'd6;
        m_pages = '0;
        m_dly   = '0;
        m_seq   = '0;
    endtask

    // effect of one accepted write, seen one cycle after ack
    task automatic apply_write(input logic [9:0] a, input logic [31:0] d);
        if (a[9:7] == 3'b001) begin           // 'h080..'h0ff
            m_dly.dly_data = d[7:0];
            m_dly.dly_addr = a[6:0];
            m_dly.ld_delay = 1'b1;
        end else if (a == 10'h070) begin
            m_dly.dly_set = 1'b1;
        end else if (a[9:4] == 6'h00) begin   // 16 run channels
            m_seq.run_addr = d[10:0];
            m_seq.run_chn  = a[3:0];
            m_seq.run_seq  = ~m_levels.ddr_rst;
        end else if (a[9:4] == 6'h02) begin
            case (a[3:0])
                4'h0: {m_patt.dqm_pattern, m_patt.dqs_pattern} = d[15:0];
                4'h1: {m_patt.dqs_tri_off, m_patt.dqs_tri_on,
                       m_patt.dq_tri_off, m_patt.dq_tri_on} = d[15:0];
                4'h2: m_patt.wbuf_delay = d[3:0];
                4'h3: {m_pages.port1_page, m_pages.port1_int_page,
                       m_pages.port0_page, m_pages.port0_int_page} = d[7:0];
                4'h4, 4'h5: m_levels.cmda_en = a[0];
                4'h6, 4'h7: m_levels.ddr_rst = a[0];
                4'h8, 4'h9: m_levels.ddr_cke = a[0];
                4'ha, 4'hb: m_levels.dci_rst = a[0];
                4'hc, 4'hd: m_levels.dly_rst = a[0];
                4'he: m_levels.inv_clk_div = d[0];
                default: ;                    // 'h02f is unmapped
            endcase
        end
    endtask

    task automatic end_pulses();
        m_dly.ld_delay = 1'b0; // operands stay
        m_dly.dly_set  = 1'b0;
        m_seq.run_seq  = 1'b0;
    endtask

`endif

// File: bench/tb_ddrc_control.sv
// ------------------------------------------------------------
// testbench for the DDR3 control block; random Wishbone
// cycles from a fixed seed, one at a time, against a model
// outputs are sampled on the falling clock edge
// ------------------------------------------------------------
`timescale 1ns/1ps

module tb_ddrc_control;

    import ddrc_ctrl_pkg::*;

    logic         clk;
    logic         mclk;
    logic         cyc;
    logic         stb;
    logic         we;
    logic [9:0]   adr;
    logic [31:0]  dat;
    logic         ack;
    logic         err;
    ctrl_levels_t levels;
    ctrl_patt_t   patt;
    ctrl_pages_t  pages;
    dly_cmd_t     dly;
    seq_cmd_t     seq;

    integer      seed;
    int          check_count;
    int          err_count;
    int          test_errs;  // err_count when the current test began
    int          i;
    logic        timed_out;
    logic [31:0] r;

    `include "tb_ddrc_model.svh"

    ddrc_control_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    function automatic logic [31:0] rnd32();
        rnd32 = $random(seed);
    endfunction

    task check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task compare_outputs();
        check_val("levels", 64'(levels), 64'(m_levels));
        check_val("patt", 64'(patt), 64'(m_patt));
        check_val("pages", 64'(pages), 64'(m_pages));
        check_val("dly", 64'(dly), 64'(m_dly));
        check_val("seq", 64'(seq), 64'(m_seq));
    endtask

    // one classic cycle, then the ack cycle, effect cycle and the cycle after
    task bus_cycle(input logic wr, input logic [9:0] a, input logic [31:0] d);
        int   waited;
        logic answered;
        if (!timed_out) begin
            @(posedge clk);
            cyc <= 1'b1;
            stb <= 1'b1;
            we  <= wr;
            adr <= a;
            dat <= d;
            waited   = 0;
            answered = 1'b0;
            while (!answered && waited < 20) begin
                @(negedge clk);
                waited++;
                answered = ack | err;
            end
            if (!answered) begin
                $display("timeout: no ack or err within 20 cycles for address %h", a);
                timed_out = 1'b1;
            end else begin
                check_val("ack", 64'(ack), 64'(wr));
                check_val("err", 64'(err), 64'(!wr));
                // request is seen at the edge after the drive edge
                check_val("ack_latency", 64'(waited), 64'd2);
                compare_outputs(); // nothing visible yet
            end
            @(posedge clk);
            cyc <= 1'b0;
            stb <= 1'b0;
            we  <= 1'b0;
            if (answered) begin
                if (wr)
                    apply_write(a, d); // reads leave the map alone
                @(negedge clk);
                check_val("ack", 64'(ack), 64'd0); // single answer per request
                check_val("err", 64'(err), 64'd0);
                compare_outputs();
                end_pulses();
                @(negedge clk);
                compare_outputs(); // pulses gone after one cycle
            end
        end
    endtask

    task end_test(input string name);
        $display("test %s: %0d mismatches", name, err_count - test_errs);
        test_errs = err_count;
    endtask

    initial begin
        seed        = 32'h6aee_c4db;
        check_count = 0;
        err_count   = 0;
        test_errs   = 0;
        timed_out   = 1'b0;
        mclk <= 1'b1;
        cyc  <= 1'b0;
        stb  <= 1'b0;
        we   <= 1'b0;
        adr  <= '0;
        dat  <= '0;
        reset_model();
        repeat (16) @(posedge clk);
        mclk <= 1'b0;
        @(negedge clk);
        check_val("ack", 64'(ack), 64'd0);
        check_val("err", 64'(err), 64'd0);
        compare_outputs();
        end_test("reset_values");
        for (i = 0; i < 60; i++) begin
            r = rnd32();
            if (r[31])
                bus_cycle(1'b1, {6'h02, r[3:0]}, rnd32()); // data and level block
            else
                bus_cycle(1'b1, r[9:0], rnd32());          // anywhere
        end
        end_test("registers_levels");
        for (i = 0; i < 16; i++) begin
            r = rnd32();
            if (r[31:30] == 2'b00)
                bus_cycle(1'b1, 10'h070, rnd32());
            else
                bus_cycle(1'b1, {3'b001, r[6:0]}, rnd32());
        end
        end_test("delay_commands");
        bus_cycle(1'b1, 10'h027, rnd32()); // DDR3 reset on
        for (i = 0; i < 4; i++) begin
            r = rnd32();
            bus_cycle(1'b1, {6'h00, r[3:0]}, rnd32());
        end
        bus_cycle(1'b1, 10'h026, rnd32()); // DDR3 reset off
        for (i = 0; i < 4; i++) begin
            r = rnd32();
            bus_cycle(1'b1, {6'h00, r[3:0]}, rnd32());
        end
        end_test("run_gating");
        for (i = 0; i < 8; i++) begin
            r = rnd32();
            bus_cycle(1'b0, r[0] ? {6'h02, r[4:1]} : r[9:0], rnd32());
        end
        end_test("read_cycles");
        $display("checks %0d, errors %0d", check_count, err_count);
        if (timed_out || err_count != 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
+incdir+bench
src/ddrc_ctrl_pkg.sv
src/ddrc_wb_slave.sv
src/ddrc_cmd_decode.sv
src/ddrc_ctrl_regs.sv
src/ddrc_cmd_pulses.sv
src/ddrc_control_top.sv
bench/tb_ddrc_control.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DDR3 control block testbench with Verilator.
# The run counts as passed only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_ddrc_control \
    -f sources.f \
    -o tb_ddrc_control

./obj_dir/tb_ddrc_control > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
    exit 0
else
    exit 1
fi
